//--- run_sim.sh
#!/bin/sh
# Build and run the sm83_lite testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_sm83_lite \
    -f sm83_lite.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "TB PASSED" sim.log; then
    exit 0
fi
exit 1

//--- sm83_lite.f
src/sm83_pkg.sv
src/bus_cycle.sv
src/micro_decoder.sv
src/exec_datapath.sv
src/int_ctrl.sv
src/sm83_lite.sv
verif/bus_checker.sv
verif/tb_sm83_lite.sv

//--- src/bus_cycle.sv
`timescale 1ns/10ps
`default_nettype none

module bus_cycle (
    input  wire                     clk,
    input  wire                     rst,
    input  wire sm83_pkg::bus_op_e  bus_op,
    input  wire sm83_pkg::addr_t    bus_addr,
    input  wire sm83_pkg::byte_t    acc,
    input  wire sm83_pkg::byte_t    din,
    output sm83_pkg::tstate_e       tstate,
    output logic                    mcycle_end,
    output sm83_pkg::byte_t         opcode,
    output sm83_pkg::byte_t         imm,
    output sm83_pkg::addr_t         a,
    output logic                    rd,
    output logic                    wr,
    output sm83_pkg::byte_t         dout
);

    assign mcycle_end = (tstate == sm83_pkg::T3);

    ////////////////////////////////////////////////////////////
    // T-state counter and bus strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tstate <= sm83_pkg::T0;
            a      <= sm83_pkg::RESET_PC;
            rd     <= 1'b0;
            wr     <= 1'b0;
            dout   <= 8'h00;
        end else begin
            tstate <= sm83_pkg::tstate_e'(tstate + 2'd1);   // Wraps T3 -> T0
            case (tstate)
                sm83_pkg::T0: begin
                    a  <= bus_addr;   // Seen from T1
                    rd <= (bus_op == sm83_pkg::BUS_FETCH) || (bus_op == sm83_pkg::BUS_READ);
                end
                sm83_pkg::T2: begin
                    rd <= 1'b0;
                    if (bus_op == sm83_pkg::BUS_WRITE) begin
                        wr   <= 1'b1;   // One clock, during T3
                        dout <= acc;
                    end
                end
                sm83_pkg::T3: begin
                    rd <= 1'b0;
                    wr <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // Read data capture, din still valid while rd is high at T2
    always_ff @(posedge clk) begin
        if (tstate == sm83_pkg::T2) begin
            if (bus_op == sm83_pkg::BUS_FETCH) begin
                opcode <= din;
            end else if (bus_op == sm83_pkg::BUS_READ) begin
                imm <= din;
            end
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr));

endmodule

`default_nettype wire

//--- src/exec_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module exec_datapath (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       mcycle_end,
    input  wire sm83_pkg::byte_t      imm,
    input  wire sm83_pkg::alu_op_e    alu_op,
    input  wire                       acc_we,
    input  wire                       flags_we,
    input  wire sm83_pkg::addr_src_e  addr_src,
    input  wire                       pc_inc,
    input  wire                       pc_rel,
    input  wire                       pc_vec,
    input  wire sm83_pkg::addr_t      int_vector,
    output sm83_pkg::byte_t           acc,
    output sm83_pkg::flags_t          flags,
    output sm83_pkg::addr_t           bus_addr
);

    sm83_pkg::addr_t  pc;
    sm83_pkg::byte_t  alu_res;
    sm83_pkg::flags_t alu_flags;
    logic [8:0] full;   // Bit 8 is carry or borrow
    logic [4:0] half;   // Bit 4 is carry or borrow out of bit 3

    ////////////////////////////////////////////////////////////
    // ALU, acc against imm
    ////////////////////////////////////////////////////////////
    always_comb begin
        full = {1'b0, imm};
        half = 5'd0;
        case (alu_op)
            sm83_pkg::ALU_ADD: begin
                full = {1'b0, acc} + {1'b0, imm};
                half = {1'b0, acc[3:0]} + {1'b0, imm[3:0]};
            end
            sm83_pkg::ALU_SUB: begin
                full = {1'b0, acc} - {1'b0, imm};
                half = {1'b0, acc[3:0]} - {1'b0, imm[3:0]};
            end
            default: ;
        endcase
        alu_res = full[7:0];
        alu_flags[sm83_pkg::FLAG_Z] = (alu_res == 8'h00);
        alu_flags[sm83_pkg::FLAG_N] = (alu_op == sm83_pkg::ALU_SUB);
        alu_flags[sm83_pkg::FLAG_H] = half[4];
        alu_flags[sm83_pkg::FLAG_C] = full[8];
    end

    // Architectural state, written once per machine cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= 8'h00;
            flags <= 4'h0;
            pc    <= sm83_pkg::RESET_PC;
        end else if (mcycle_end) begin
            if (acc_we) begin
                acc <= alu_res;
            end
            if (flags_we) begin
                flags <= alu_flags;
            end
            if (pc_vec) begin
                pc <= int_vector;
            end else if (pc_rel) begin
                pc <= pc + {{8{imm[7]}}, imm};   // Signed e8
            end else if (pc_inc) begin
                pc <= pc + 16'd1;
            end
        end
    end

    assign bus_addr = (addr_src == sm83_pkg::ADDR_HIGH_IMM) ? {sm83_pkg::HIGH_PAGE, imm} : pc;

endmodule

`default_nettype wire

//--- src/int_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module int_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire sm83_pkg::int_vec_t int_en,
    input  wire sm83_pkg::int_vec_t int_flags_in,
    input  wire                     ime_set,
    input  wire                     ime_clr,
    input  wire                     int_ack,
    output logic                    int_req,
    output logic                    wake,
    output sm83_pkg::addr_t         int_vector,
    output sm83_pkg::int_vec_t      int_flags_out
);

    logic ime;
    logic [2:0] win_idx;
    sm83_pkg::int_vec_t pending;
    sm83_pkg::int_vec_t winner;   // One-hot, lowest pending source

    assign pending = int_flags_in & int_en;
    assign winner  = pending & (~pending + sm83_pkg::int_vec_t'(1));

    always_comb begin
        win_idx = 3'd0;
        for (int i = sm83_pkg::NUM_INTS - 1; i >= 0; i--) begin
            if (pending[i]) win_idx = 3'(i);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ime <= 1'b0;
        end else if (ime_clr) begin
            ime <= 1'b0;
        end else if (ime_set) begin
            ime <= 1'b1;
        end
    end

    assign wake          = |pending;         // HALT exit needs no IME
    assign int_req       = ime && (|pending);
    assign int_vector    = sm83_pkg::INT_VECTOR_BASE +
                           sm83_pkg::INT_VECTOR_STEP * sm83_pkg::addr_t'(win_idx);
    assign int_flags_out = int_ack ? (int_flags_in & ~winner) : int_flags_in;

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst) int_ack |-> int_req);

endmodule

`default_nettype wire

//--- src/micro_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module micro_decoder (
    input  wire                     clk,
    input  wire                     rst,
    input  wire sm83_pkg::tstate_e  tstate,
    input  wire                     mcycle_end,
    input  wire sm83_pkg::byte_t    opcode,
    input  wire sm83_pkg::byte_t    imm,
    input  wire sm83_pkg::flags_t   flags,
    input  wire                     int_req,
    input  wire                     wake,
    output sm83_pkg::bus_op_e       bus_op,
    output sm83_pkg::addr_src_e     addr_src,
    output sm83_pkg::alu_op_e       alu_op,
    output logic                    acc_we,
    output logic                    flags_we,
    output logic                    pc_inc,
    output logic                    pc_rel,
    output logic                    pc_vec,
    output logic                    int_ack,
    output logic                    ime_set,
    output logic                    ime_clr,
    output logic                    done,
    output logic                    fault
);

    sm83_pkg::mcycle_t mcycle;
    logic halted;
    logic dispatch;    // Idle cycle that loads the vector
    logic last;        // Current machine cycle ends the instruction
    logic supported;
    logic taken;

    assign int_ack = dispatch;

    // Branch condition
    always_comb begin
        case (opcode)
            sm83_pkg::OPC_JR_NZ: taken = !flags[sm83_pkg::FLAG_Z];
            sm83_pkg::OPC_JR_Z:  taken = flags[sm83_pkg::FLAG_Z];
            sm83_pkg::OPC_JR_NC: taken = !flags[sm83_pkg::FLAG_C];
            sm83_pkg::OPC_JR_C:  taken = flags[sm83_pkg::FLAG_C];
            default:             taken = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Per machine cycle controls
    ////////////////////////////////////////////////////////////
    always_comb begin
        bus_op    = sm83_pkg::BUS_IDLE;
        addr_src  = sm83_pkg::ADDR_PC;
        alu_op    = sm83_pkg::ALU_PASS;
        acc_we    = 1'b0;
        flags_we  = 1'b0;
        pc_inc    = 1'b0;
        pc_rel    = 1'b0;
        pc_vec    = 1'b0;
        ime_set   = 1'b0;
        ime_clr   = 1'b0;
        last      = 1'b1;
        supported = 1'b1;
        if (dispatch && !fault) begin
            pc_vec  = 1'b1;
            ime_clr = mcycle_end;
        end else if (!fault && !halted) begin
            case (mcycle)
                2'd0: begin
                    bus_op = sm83_pkg::BUS_FETCH;
                    pc_inc = 1'b1;
                    // Opcode is only fresh from T3 on, so these act at mcycle_end
                    case (opcode)
                        sm83_pkg::OPC_NOP, sm83_pkg::OPC_HALT: ;
                        sm83_pkg::OPC_DI: ime_clr = mcycle_end;
                        sm83_pkg::OPC_EI: ime_set = mcycle_end;
                        sm83_pkg::OPC_LD_A_D8, sm83_pkg::OPC_ADD_D8, sm83_pkg::OPC_SUB_D8,
                        sm83_pkg::OPC_LDH_N_A, sm83_pkg::OPC_JR, sm83_pkg::OPC_JR_NZ,
                        sm83_pkg::OPC_JR_Z, sm83_pkg::OPC_JR_NC, sm83_pkg::OPC_JR_C: last = 1'b0;
                        default: supported = 1'b0;
                    endcase
                end
                2'd1: begin
                    bus_op = sm83_pkg::BUS_READ;   // Immediate byte
                    pc_inc = 1'b1;
                    case (opcode)
                        sm83_pkg::OPC_LD_A_D8: acc_we = 1'b1;
                        sm83_pkg::OPC_ADD_D8: begin
                            alu_op   = sm83_pkg::ALU_ADD;
                            acc_we   = 1'b1;
                            flags_we = 1'b1;
                        end
                        sm83_pkg::OPC_SUB_D8: begin
                            alu_op   = sm83_pkg::ALU_SUB;
                            acc_we   = 1'b1;
                            flags_we = 1'b1;
                        end
                        default: last = !taken;   // LDH and JR always go on
                    endcase
                end
                default: begin
                    if (opcode == sm83_pkg::OPC_LDH_N_A) begin
                        bus_op   = sm83_pkg::BUS_WRITE;
                        addr_src = sm83_pkg::ADDR_HIGH_IMM;
                    end else begin
                        pc_rel = 1'b1;   // Idle cycle of a taken JR
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequence state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcycle   <= 2'd0;
            halted   <= 1'b0;
            dispatch <= 1'b0;
            fault    <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= halted | fault;
            if (mcycle_end && !fault) begin
                if (dispatch) begin
                    dispatch <= 1'b0;   // Next cycle fetches at the vector
                end else if (halted) begin
                    if (wake) begin
                        halted   <= 1'b0;
                        dispatch <= int_req;
                    end
                end else if (last) begin
                    mcycle <= 2'd0;
                    if (!supported) begin
                        fault <= 1'b1;
                    end else if (mcycle == 2'd0 && opcode == sm83_pkg::OPC_HALT) begin
                        halted <= 1'b1;
                    end else begin
                        dispatch <= int_req;
                    end
                end else begin
                    mcycle <= mcycle + 2'd1;
                end
            end
        end
    end

    a_mcycle_range: assert property (@(posedge clk) disable iff (rst) mcycle != 2'd3);

    // Index moves only on machine cycle boundaries
    a_mcycle_step: assert property (@(posedge clk) disable iff (rst)
        !$stable(mcycle) |-> tstate == sm83_pkg::T0);

    // Offset or high address must survive until the third cycle commits
    a_imm_held: assert property (@(posedge clk) disable iff (rst)
        (mcycle == 2'd2) |-> $stable(imm));

endmodule

`default_nettype wire

//--- src/sm83_lite.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_lite (
    input  wire                     clk,
    input  wire                     rst,
    input  wire sm83_pkg::byte_t    din,
    input  wire sm83_pkg::int_vec_t int_en,
    input  wire sm83_pkg::int_vec_t int_flags_in,
    output sm83_pkg::addr_t         a,
    output sm83_pkg::byte_t         dout,
    output logic                    rd,
    output logic                    wr,
    output sm83_pkg::int_vec_t      int_flags_out,
    output logic                    done,
    output logic                    fault
);

    sm83_pkg::tstate_e   tstate;
    sm83_pkg::bus_op_e   bus_op;
    sm83_pkg::addr_src_e addr_src;
    sm83_pkg::alu_op_e   alu_op;
    sm83_pkg::byte_t     opcode;
    sm83_pkg::byte_t     imm;
    sm83_pkg::byte_t     acc;
    sm83_pkg::flags_t    flags;
    sm83_pkg::addr_t     bus_addr;
    sm83_pkg::addr_t     int_vector;
    logic mcycle_end;
    logic acc_we;
    logic flags_we;
    logic pc_inc;
    logic pc_rel;
    logic pc_vec;
    logic int_ack;
    logic ime_set;
    logic ime_clr;
    logic int_req;
    logic wake;

    bus_cycle u_bus_cycle (
        .clk        (clk),
        .rst        (rst),
        .bus_op     (bus_op),
        .bus_addr   (bus_addr),
        .acc        (acc),
        .din        (din),
        .tstate     (tstate),
        .mcycle_end (mcycle_end),
        .opcode     (opcode),
        .imm        (imm),
        .a          (a),
        .rd         (rd),
        .wr         (wr),
        .dout       (dout)
    );

    micro_decoder u_micro_decoder (
        .clk        (clk),
        .rst        (rst),
        .tstate     (tstate),
        .mcycle_end (mcycle_end),
        .opcode     (opcode),
        .imm        (imm),
        .flags      (flags),
        .int_req    (int_req),
        .wake       (wake),
        .bus_op     (bus_op),
        .addr_src   (addr_src),
        .alu_op     (alu_op),
        .acc_we     (acc_we),
        .flags_we   (flags_we),
        .pc_inc     (pc_inc),
        .pc_rel     (pc_rel),
        .pc_vec     (pc_vec),
        .int_ack    (int_ack),
        .ime_set    (ime_set),
        .ime_clr    (ime_clr),
        .done       (done),
        .fault      (fault)
    );

    exec_datapath u_exec_datapath (
        .clk        (clk),
        .rst        (rst),
        .mcycle_end (mcycle_end),
        .imm        (imm),
        .alu_op     (alu_op),
        .acc_we     (acc_we),
        .flags_we   (flags_we),
        .addr_src   (addr_src),
        .pc_inc     (pc_inc),
        .pc_rel     (pc_rel),
        .pc_vec     (pc_vec),
        .int_vector (int_vector),
        .acc        (acc),
        .flags      (flags),
        .bus_addr   (bus_addr)
    );

    int_ctrl u_int_ctrl (
        .clk           (clk),
        .rst           (rst),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .ime_set       (ime_set),
        .ime_clr       (ime_clr),
        .int_ack       (int_ack),
        .int_req       (int_req),
        .wake          (wake),
        .int_vector    (int_vector),
        .int_flags_out (int_flags_out)
    );

endmodule

`default_nettype wire

//--- src/sm83_pkg.sv
`default_nettype none

package sm83_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  flags_t;
    typedef logic [4:0]  int_vec_t;
    typedef logic [1:0]  mcycle_t;   // Index within one instruction

    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_H = 1;
    localparam int FLAG_C = 0;

    typedef enum logic [1:0] {T0, T1, T2, T3} tstate_e;
    typedef enum logic [1:0] {BUS_IDLE, BUS_FETCH, BUS_READ, BUS_WRITE} bus_op_e;
    typedef enum logic {ADDR_PC, ADDR_HIGH_IMM} addr_src_e;
    typedef enum logic [1:0] {ALU_PASS, ALU_ADD, ALU_SUB} alu_op_e;

    ////////////////////////////////////////////////////////////
    // Supported opcodes
    ////////////////////////////////////////////////////////////
    localparam byte_t OPC_NOP     = 8'h00;
    localparam byte_t OPC_LD_A_D8 = 8'h3E;
    localparam byte_t OPC_ADD_D8  = 8'hC6;
    localparam byte_t OPC_SUB_D8  = 8'hD6;
    localparam byte_t OPC_LDH_N_A = 8'hE0;
    localparam byte_t OPC_JR      = 8'h18;
    localparam byte_t OPC_JR_NZ   = 8'h20;
    localparam byte_t OPC_JR_Z    = 8'h28;
    localparam byte_t OPC_JR_NC   = 8'h30;
    localparam byte_t OPC_JR_C    = 8'h38;
    localparam byte_t OPC_HALT    = 8'h76;
    localparam byte_t OPC_DI      = 8'hF3;
    localparam byte_t OPC_EI      = 8'hFB;

    localparam addr_t RESET_PC  = 16'h0000;
    localparam byte_t HIGH_PAGE = 8'hFF;   // LDH target page

    // Interrupt vectors at 0040, 0048, ... 0060
    localparam addr_t INT_VECTOR_BASE = 16'h0040;
    localparam addr_t INT_VECTOR_STEP = 16'd8;
    localparam int    NUM_INTS        = 5;

endpackage

`default_nettype wire

//--- verif/bus_checker.sv
`timescale 1ns/10ps
`default_nettype none

module bus_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire sm83_pkg::addr_t    a,
    input  wire                     rd,
    input  wire                     wr,
    input  wire sm83_pkg::byte_t    dout,
    input  wire                     fetch,
    input  wire                     fault,
    input  wire sm83_pkg::int_vec_t int_flags_in,
    input  wire sm83_pkg::int_vec_t int_flags_out
);

    localparam int MAX_EV   = 4;
    localparam int EV_FETCH = 1;
    localparam int EV_WRITE = 2;

    int                 kind [MAX_EV];
    sm83_pkg::addr_t    ev_a [MAX_EV];
    sm83_pkg::byte_t    ev_d [MAX_EV];
    int                 next_ev;
    int                 n_disp;
    int                 exp_disp;
    sm83_pkg::int_vec_t exp_flags;
    int                 errors = 0;
    logic               rd_q;
    logic               disp_q;
    logic               disp;

    assign disp = (int_flags_out != int_flags_in);   // Serviced bit cleared

    task automatic start_case(input int nd, input sm83_pkg::int_vec_t fl);
        next_ev   = 0;
        n_disp    = 0;
        exp_disp  = nd;
        exp_flags = fl;
        for (int k = 0; k < MAX_EV; k++) begin
            kind[k] = 0;
        end
    endtask

    task automatic expect_event(input int k, input int knd, input sm83_pkg::addr_t ad,
                                input sm83_pkg::byte_t d);
        kind[k] = knd;
        ev_a[k] = ad;
        ev_d[k] = d;
    endtask

    task automatic end_case(input int c);
        if (next_ev < MAX_EV && kind[next_ev] != 0) begin
            errors++;
            $display("Case %0d ended before expected event %0d was seen", c, next_ev);
        end
        if (n_disp != exp_disp) begin
            errors++;
            $display("Case %0d saw %0d dispatch cycles, %0d expected", c, n_disp, exp_disp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Event matching on each rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            rd_q   = 1'b0;
            disp_q = 1'b0;
        end else begin
            if (fault && (rd || wr)) begin
                errors++;
                $display("Bus activity at %0t after the fault was raised", $time);
            end
            // Fetch address shows on the first clock of rd
            if (rd && !rd_q && fetch && next_ev < MAX_EV && kind[next_ev] == EV_FETCH
                && a == ev_a[next_ev]) begin
                next_ev++;
            end
            if (wr) begin
                if (next_ev >= MAX_EV || kind[next_ev] != EV_WRITE) begin
                    errors++;
                    $display("Unexpected write of %02h to %04h at %0t", dout, a, $time);
                end else begin
                    if (a != ev_a[next_ev]) begin
                        errors++;
                        $display("[ERROR] %0t a expected %04h actual %04h",
                                 $time, ev_a[next_ev], a);
                    end
                    if (dout != ev_d[next_ev]) begin
                        errors++;
                        $display("[ERROR] %0t dout expected %02h actual %02h",
                                 $time, ev_d[next_ev], dout);
                    end
                    next_ev++;
                end
            end
            if (disp) begin
                if (int_flags_out != exp_flags) begin
                    errors++;
                    $display("[ERROR] %0t int_flags_out expected %05b actual %05b",
                             $time, exp_flags, int_flags_out);
                end
                if (!disp_q) begin
                    n_disp++;
                end
            end
            rd_q   = rd;
            disp_q = disp;
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_sm83_lite.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sm83_lite;

    localparam int N_CASES     = 8;
    localparam int MAX_EV      = 4;
    localparam int EV_FETCH    = 1;
    localparam int EV_WRITE    = 2;
    localparam int POST_CYCLES = 16;   // Quiet bus check after done

    logic               clk;
    logic               rst;
    sm83_pkg::byte_t    din;
    sm83_pkg::int_vec_t int_en;
    sm83_pkg::int_vec_t int_flags_in;
    sm83_pkg::addr_t    a;
    sm83_pkg::byte_t    dout;
    logic               rd;
    logic               wr;
    sm83_pkg::int_vec_t int_flags_out;
    logic               done;
    logic               fault;

    logic [7:0] mem [0:65535];

    // Test table
    int                 main_len    [N_CASES];
    logic [191:0]       main_bits   [N_CASES];   // Loaded at 0000, first byte leftmost
    sm83_pkg::addr_t    isr_addr    [N_CASES];
    int                 isr_len     [N_CASES];
    logic [63:0]        isr_bits    [N_CASES];
    sm83_pkg::int_vec_t en_val      [N_CASES];
    sm83_pkg::int_vec_t flags_val   [N_CASES];
    int                 apply_cycle [N_CASES];
    logic               exp_halt    [N_CASES];   // Halted when the flag is applied
    int                 ev_kind     [N_CASES][MAX_EV];
    sm83_pkg::addr_t    ev_addr     [N_CASES][MAX_EV];
    sm83_pkg::byte_t    ev_data     [N_CASES][MAX_EV];
    int                 exp_disp    [N_CASES];
    sm83_pkg::int_vec_t exp_flags   [N_CASES];
    int                 mcycles     [N_CASES];

    int cycle = 0;
    int limit = 100000;
    int case_cycle;
    int tb_errors = 0;

    sm83_lite u_dut (
        .clk           (clk),
        .rst           (rst),
        .din           (din),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .a             (a),
        .dout          (dout),
        .rd            (rd),
        .wr            (wr),
        .int_flags_out (int_flags_out),
        .done          (done),
        .fault         (fault)
    );

    bus_checker u_chk (
        .clk           (clk),
        .rst           (rst),
        .a             (a),
        .rd            (rd),
        .wr            (wr),
        .dout          (dout),
        .fetch         (u_dut.bus_op == sm83_pkg::BUS_FETCH),
        .fault         (fault),
        .int_flags_in  (int_flags_in),
        .int_flags_out (int_flags_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////
    assign din = rd ? mem[a] : 8'h00;

    always @(posedge clk) begin
        if (wr) begin
            mem[a] = dout;   // High page keeps what was written
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        while (cycle < limit) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, done never came", cycle);
        $display("TB FAILED");
        $finish;
    end

    task automatic add_event(input int c, input int k, input int knd,
                             input sm83_pkg::addr_t ad, input sm83_pkg::byte_t d);
        ev_kind[c][k] = knd;
        ev_addr[c][k] = ad;
        ev_data[c][k] = d;
    endtask

    task automatic build_table();
        for (int c = 0; c < N_CASES; c++) begin
            isr_addr[c]    = 16'h0000;
            isr_len[c]     = 0;
            isr_bits[c]    = 64'h0;
            en_val[c]      = 5'b00000;
            flags_val[c]   = 5'b00000;
            apply_cycle[c] = 0;
            exp_halt[c]    = 1'b0;
            exp_disp[c]    = 0;
            exp_flags[c]   = 5'b00000;
            for (int k = 0; k < MAX_EV; k++) begin
                add_event(c, k, 0, 16'h0000, 8'h00);
            end
        end
        // LD, ADD with wrap to 15, SUB with borrow to F5
        main_len[0]  = 11;
        main_bits[0] = 192'h3EF0_C625_E080_D620_E081_CB;
        mcycles[0]   = 13;
        add_event(0, 0, EV_WRITE, 16'hFF80, 8'h15);
        add_event(0, 1, EV_WRITE, 16'hFF81, 8'hF5);
        // 80+80 sets Z and C, JR Z taken, JR NC falls through
        main_len[1]  = 17;
        main_bits[1] = 192'h3E80_C680_2802_3E11_E080_3002_3E22_E081_CB;
        mcycles[1]   = 18;
        add_event(1, 0, EV_WRITE, 16'hFF80, 8'h00);
        add_event(1, 1, EV_WRITE, 16'hFF81, 8'h22);
        // 05-06 clears Z and sets C, JR NZ and JR C taken, JR Z falls through
        main_len[2]  = 21;
        main_bits[2] = 192'h3E05_D606_2002_3E11_3802_3E22_E082_2802_3E33_E083_CB;
        mcycles[2]   = 21;
        add_event(2, 0, EV_WRITE, 16'hFF82, 8'hFF);
        add_event(2, 1, EV_WRITE, 16'hFF83, 8'h33);
        // Count down from 3, JR NZ back by 4
        main_len[3]  = 9;
        main_bits[3] = 192'h3E03_D601_20FC_E084_CB;
        mcycles[3]   = 20;
        add_event(3, 0, EV_FETCH, 16'h0006, 8'h00);
        add_event(3, 1, EV_WRITE, 16'hFF84, 8'h00);
        // EI then dispatch of source 1 to 0048
        main_len[4]  = 3;
        main_bits[4] = 192'hFB00_CB;
        isr_addr[4]  = 16'h0048;
        isr_len[4]   = 5;
        isr_bits[4]  = 64'h3E5A_E090_CB;
        en_val[4]    = 5'b11111;
        flags_val[4] = 5'b10110;
        exp_disp[4]  = 1;
        exp_flags[4] = 5'b10100;
        mcycles[4]   = 9;
        add_event(4, 0, EV_FETCH, 16'h0048, 8'h00);
        add_event(4, 1, EV_WRITE, 16'hFF90, 8'h5A);
        // HALT with IME off, wake at cycle 40
        main_len[5]    = 6;
        main_bits[5]   = 192'h763E_33E0_81CB;
        isr_addr[5]    = 16'h0040;
        isr_len[5]     = 5;
        isr_bits[5]    = 64'h3EEE_E081_CB;
        en_val[5]      = 5'b00001;
        flags_val[5]   = 5'b00001;
        apply_cycle[5] = 40;
        exp_halt[5]    = 1'b1;
        mcycles[5]     = 18;
        add_event(5, 0, EV_FETCH, 16'h0001, 8'h00);
        add_event(5, 1, EV_WRITE, 16'hFF81, 8'h33);
        // EI then DI, flag raised afterwards
        main_len[6]    = 7;
        main_bits[6]   = 192'hFBF3_3E77_E082_CB;
        isr_addr[6]    = 16'h0050;
        isr_len[6]     = 5;
        isr_bits[6]    = 64'h3EEE_E082_CB;
        en_val[6]      = 5'b11111;
        flags_val[6]   = 5'b00100;
        apply_cycle[6] = 12;
        mcycles[6]     = 8;
        add_event(6, 0, EV_WRITE, 16'hFF82, 8'h77);
        // Unsupported CB
        main_len[7]  = 3;
        main_bits[7] = 192'h3E11_CB;
        mcycles[7]   = 3;
        add_event(7, 0, EV_FETCH, 16'h0002, 8'h00);
    endtask

    task automatic load_memory(input int c);
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        end
        for (int i = 0; i < main_len[c]; i++) begin
            mem[16'(i)] = main_bits[c][8 * (main_len[c] - 1 - i) +: 8];
        end
        for (int i = 0; i < isr_len[c]; i++) begin
            mem[isr_addr[c] + 16'(i)] = isr_bits[c][8 * (isr_len[c] - 1 - i) +: 8];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One case: reset, run until done, then watch a quiet bus
    ////////////////////////////////////////////////////////////
    task automatic run_case(input int c);
        rst          = 1'b1;
        int_en       = 5'b00000;
        int_flags_in = 5'b00000;
        load_memory(c);
        u_chk.start_case(exp_disp[c], exp_flags[c]);
        for (int k = 0; k < MAX_EV; k++) begin
            u_chk.expect_event(k, ev_kind[c][k], ev_addr[c][k], ev_data[c][k]);
        end
        repeat (3) @(posedge clk);
        #2;
        rst          = 1'b0;
        int_en       = en_val[c];
        int_flags_in = (apply_cycle[c] == 0) ? flags_val[c] : 5'b00000;
        case_cycle   = 0;
        // done from a HALT before the flag does not end the case
        while (!(done && case_cycle > apply_cycle[c] + 8)) begin
            @(posedge clk);
            #2;
            case_cycle++;
            if (apply_cycle[c] > 0 && case_cycle == apply_cycle[c]) begin
                if (exp_halt[c] && (!done || fault)) begin
                    tb_errors++;
                    $display("Case %0d: done did not rise while halted", c);
                end
                int_flags_in = flags_val[c];
            end
        end
        // Every program ends on the unsupported CB
        if (!fault) begin
            tb_errors++;
            $display("[ERROR] %0t fault expected 1 actual %0b", $time, fault);
        end
        repeat (POST_CYCLES) @(posedge clk);
        #2;
        u_chk.end_case(c);
    endtask

    initial begin
        int total_mc;
        int total_err;
        rst          = 1'b1;
        int_en       = 5'b00000;
        int_flags_in = 5'b00000;
        build_table();
        total_mc = 0;
        for (int c = 0; c < N_CASES; c++) begin
            total_mc += mcycles[c];
        end
        limit = total_mc * 4 * 2 + 200;
        @(posedge clk);
        #2;
        for (int c = 0; c < N_CASES; c++) begin
            run_case(c);
        end
        total_err = tb_errors + u_chk.errors;
        $display("Closing: %0d errors (%0d checker, %0d testbench)",
                 total_err, u_chk.errors, tb_errors);
        if (total_err == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
